/* design/mips_pkg.sv */
package mips_pkg;

   //////////////////////////////////////////////////////////////////////
   // Datapath widths.
   //////////////////////////////////////////////////////////////////////

   localparam int INSTR_W    = 32;
   localparam int DATA_W     = 32;
   localparam int NUM_REGS   = 32;
   localparam int REG_ADDR_W = 5;
   localparam int IMM_W      = 16;

   // Word addressed with 64 instructions.
   localparam int PC_W       = 6;

   //////////////////////////////////////////////////////////////////////
   // Opcodes and R-type function codes.
   //////////////////////////////////////////////////////////////////////

   localparam logic [5:0] OP_RTYPE = 6'd0;
   localparam logic [5:0] OP_BEQZ  = 6'd4;
   localparam logic [5:0] OP_ADDIU = 6'd9;
   localparam logic [5:0] OP_HALT  = 6'd63;

   localparam logic [5:0] FN_ADDU  = 6'h21;
   localparam logic [5:0] FN_SUBU  = 6'h23;
   localparam logic [5:0] FN_AND   = 6'h24;
   localparam logic [5:0] FN_OR    = 6'h25;
   localparam logic [5:0] FN_SLT   = 6'h2a;

   // ALU operation selected by the decoder.
   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_SLT = 3'd4
   } alu_op_t;

endpackage

/* design/instr_fetch.sv */
`timescale 1ns/10ps

module instr_fetch
   import mips_pkg::*;
   (
      input  logic               i_clock,
      input  logic               i_arst_n,
      input  logic               i_run,
      input  logic               i_load_en,
      input  logic [PC_W-1:0]    i_load_addr,
      input  logic [INSTR_W-1:0] i_load_data,
      input  logic               i_branch_taken,
      input  logic [PC_W-1:0]    i_branch_target,
      input  logic               i_is_halt,
      output logic [INSTR_W-1:0] o_instr,
      output logic [PC_W-1:0]    o_pc,
      output logic [PC_W-1:0]    o_pc_plus1,
      output logic               o_running,
      output logic               o_halt
   );

   logic [INSTR_W-1:0] imem [0:(2**PC_W)-1];
   logic [PC_W-1:0]    pc;
   logic               halted;

   // Program load only while the core is idle.
   always_ff @(posedge i_clock) begin
      if (i_load_en && !i_run) begin
         imem[i_load_addr] <= i_load_data;
      end
   end

   assign o_instr    = imem[pc];
   assign o_pc_plus1 = pc + 1'b1;
   assign o_running  = i_run && !halted;

   //////////////////////////////////////////////////////////////////////
   // PC and halt state.
   //////////////////////////////////////////////////////////////////////

   // PC stays on the HALT word once it executes.
   always_ff @(posedge i_clock or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pc     <= '0;
         halted <= 1'b0;
      end else if (o_running) begin
         if (i_is_halt) begin
            halted <= 1'b1;
         end else if (i_branch_taken) begin
            pc <= i_branch_target;
         end else begin
            pc <= o_pc_plus1;
         end
      end
   end

   assign o_pc   = pc;
   assign o_halt = halted;

endmodule

/* design/decoder.sv */
`timescale 1ns/10ps

module decoder
   import mips_pkg::*;
   (
      input  logic [INSTR_W-1:0]    i_instruction,
      output logic [REG_ADDR_W-1:0] o_reg_a,
      output logic [REG_ADDR_W-1:0] o_reg_b,
      output logic [REG_ADDR_W-1:0] o_reg_w,
      output logic [IMM_W-1:0]      o_immediate,
      output alu_op_t               o_alu_op,
      output logic                  o_use_imm,
      output logic                  o_wr_en,
      output logic                  o_flag_branch,
      output logic                  o_is_halt
   );

   logic [5:0]            opcode;
   logic [5:0]            funct;
   logic [REG_ADDR_W-1:0] rd;

   // Fixed MIPS field positions.
   assign opcode      = i_instruction[31:26];
   assign o_reg_a     = i_instruction[25:21];
   assign o_reg_b     = i_instruction[20:16];
   assign rd          = i_instruction[15:11];
   assign funct       = i_instruction[5:0];
   assign o_immediate = i_instruction[IMM_W-1:0];

   always_comb begin
      o_reg_w       = rd;
      o_alu_op      = ALU_ADD;
      o_use_imm     = 1'b0;
      o_wr_en       = 1'b0;
      o_flag_branch = 1'b0;
      o_is_halt     = 1'b0;
      case (opcode)
         OP_RTYPE: begin
            o_wr_en = 1'b1;
            case (funct)
               FN_ADDU: o_alu_op = ALU_ADD;
               FN_SUBU: o_alu_op = ALU_SUB;
               FN_AND:  o_alu_op = ALU_AND;
               FN_OR:   o_alu_op = ALU_OR;
               FN_SLT:  o_alu_op = ALU_SLT;
               // Unknown function writes nothing.
               default: o_wr_en  = 1'b0;
            endcase
         end
         OP_ADDIU: begin
            o_reg_w   = o_reg_b;
            o_use_imm = 1'b1;
            o_wr_en   = 1'b1;
         end
         OP_BEQZ: o_flag_branch = 1'b1;
         OP_HALT: o_is_halt     = 1'b1;
         default: ;
      endcase
   end

endmodule

/* design/register_file.sv */
`timescale 1ns/10ps

module register_file
   import mips_pkg::*;
   (
      input  logic                  i_clock,
      input  logic                  i_arst_n,
      input  logic [REG_ADDR_W-1:0] i_reg_a,
      input  logic [REG_ADDR_W-1:0] i_reg_b,
      input  logic [REG_ADDR_W-1:0] i_reg_write,
      input  logic [DATA_W-1:0]     i_data_write,
      input  logic                  i_control_write,
      output logic [DATA_W-1:0]     o_data_a,
      output logic [DATA_W-1:0]     o_data_b
   );

   logic [DATA_W-1:0] regs [0:NUM_REGS-1];

   // Writes to register 0 are dropped.
   always_ff @(posedge i_clock or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_control_write && (i_reg_write != '0)) begin
         regs[i_reg_write] <= i_data_write;
      end
   end

   // Asynchronous reads.
   assign o_data_a = (i_reg_a == '0) ? '0 : regs[i_reg_a];
   assign o_data_b = (i_reg_b == '0) ? '0 : regs[i_reg_b];

endmodule

/* design/instr_decode.sv */
`timescale 1ns/10ps

module instr_decode
   import mips_pkg::*;
   (
      input  logic                  i_clock,
      input  logic                  i_arst_n,
      input  logic [INSTR_W-1:0]    i_instruction,
      input  logic [PC_W-1:0]       i_pc_plus1,
      input  logic                  i_running,
      input  logic [DATA_W-1:0]     i_wb_data,
      output logic [DATA_W-1:0]     o_data_a,
      output logic [DATA_W-1:0]     o_data_b,
      output logic [DATA_W-1:0]     o_imm_ext,
      output logic                  o_use_imm,
      output alu_op_t               o_alu_op,
      output logic                  o_wr_en,
      output logic [REG_ADDR_W-1:0] o_wr_reg,
      output logic                  o_branch_taken,
      output logic [PC_W-1:0]       o_branch_target,
      output logic                  o_is_halt
   );

   logic [REG_ADDR_W-1:0] reg_a;
   logic [REG_ADDR_W-1:0] reg_b;
   logic [IMM_W-1:0]      immediate;
   logic                  dec_wr_en;
   logic                  flag_branch;

   decoder u_decoder_1 (
      .i_instruction (i_instruction),
      .o_reg_a       (reg_a),
      .o_reg_b       (reg_b),
      .o_reg_w       (o_wr_reg),
      .o_immediate   (immediate),
      .o_alu_op      (o_alu_op),
      .o_use_imm     (o_use_imm),
      .o_wr_en       (dec_wr_en),
      .o_flag_branch (flag_branch),
      .o_is_halt     (o_is_halt)
   );

   assign o_wr_en = dec_wr_en && i_running;

   register_file u_register_file_1 (
      .i_clock         (i_clock),
      .i_arst_n        (i_arst_n),
      .i_reg_a         (reg_a),
      .i_reg_b         (reg_b),
      .i_reg_write     (o_wr_reg),
      .i_data_write    (i_wb_data),
      .i_control_write (o_wr_en),
      .o_data_a        (o_data_a),
      .o_data_b        (o_data_b)
   );

   //////////////////////////////////////////////////////////////////////
   // Immediate and branch.
   //////////////////////////////////////////////////////////////////////

   assign o_imm_ext = {{(DATA_W-IMM_W){immediate[IMM_W-1]}}, immediate};

   // PC counts words, so the offset is added unshifted.
   assign o_branch_target = i_pc_plus1 + o_imm_ext[PC_W-1:0];
   assign o_branch_taken  = flag_branch && (o_data_a == '0) && i_running;

endmodule

/* design/execute.sv */
`timescale 1ns/10ps

module execute
   import mips_pkg::*;
   (
      input  logic [DATA_W-1:0] i_data_a,
      input  logic [DATA_W-1:0] i_data_b,
      input  logic [DATA_W-1:0] i_imm_ext,
      input  logic              i_use_imm,
      input  alu_op_t           i_alu_op,
      output logic [DATA_W-1:0] o_result
   );

   logic [DATA_W-1:0] operand_b;
   logic              less_than;

   // Second operand is rt or the extended immediate.
   assign operand_b = i_use_imm ? i_imm_ext : i_data_b;
   assign less_than = $signed(i_data_a) < $signed(operand_b);

   always_comb begin
      case (i_alu_op)
         ALU_ADD: o_result = i_data_a + operand_b;
         ALU_SUB: o_result = i_data_a - operand_b;
         ALU_AND: o_result = i_data_a & operand_b;
         ALU_OR:  o_result = i_data_a | operand_b;
         ALU_SLT: o_result = {{(DATA_W-1){1'b0}}, less_than};
         default: o_result = '0;
      endcase
   end

endmodule

/* design/mips_core.sv */
`timescale 1ns/10ps

module mips_core
   import mips_pkg::*;
   (
      input  logic                  i_clock,
      input  logic                  i_arst_n,
      input  logic                  i_run,
      input  logic                  i_load_en,
      input  logic [PC_W-1:0]       i_load_addr,
      input  logic [INSTR_W-1:0]    i_load_data,
      output logic [PC_W-1:0]       o_pc,
      output logic                  o_halt,
      output logic                  o_wb_en,
      output logic [REG_ADDR_W-1:0] o_wb_reg,
      output logic [DATA_W-1:0]     o_wb_data
   );

   logic [INSTR_W-1:0]    instr;
   logic [PC_W-1:0]       pc_plus1;
   logic                  running;
   logic                  branch_taken;
   logic [PC_W-1:0]       branch_target;
   logic                  is_halt;
   logic [DATA_W-1:0]     data_a;
   logic [DATA_W-1:0]     data_b;
   logic [DATA_W-1:0]     imm_ext;
   logic                  use_imm;
   alu_op_t               alu_op;
   logic                  wr_en;
   logic [REG_ADDR_W-1:0] wr_reg;
   logic [DATA_W-1:0]     wb_data;

   instr_fetch u_instr_fetch_1 (
      .i_clock         (i_clock),
      .i_arst_n        (i_arst_n),
      .i_run           (i_run),
      .i_load_en       (i_load_en),
      .i_load_addr     (i_load_addr),
      .i_load_data     (i_load_data),
      .i_branch_taken  (branch_taken),
      .i_branch_target (branch_target),
      .i_is_halt       (is_halt),
      .o_instr         (instr),
      .o_pc            (o_pc),
      .o_pc_plus1      (pc_plus1),
      .o_running       (running),
      .o_halt          (o_halt)
   );

   instr_decode u_instr_decode_1 (
      .i_clock         (i_clock),
      .i_arst_n        (i_arst_n),
      .i_instruction   (instr),
      .i_pc_plus1      (pc_plus1),
      .i_running       (running),
      .i_wb_data       (wb_data),
      .o_data_a        (data_a),
      .o_data_b        (data_b),
      .o_imm_ext       (imm_ext),
      .o_use_imm       (use_imm),
      .o_alu_op        (alu_op),
      .o_wr_en         (wr_en),
      .o_wr_reg        (wr_reg),
      .o_branch_taken  (branch_taken),
      .o_branch_target (branch_target),
      .o_is_halt       (is_halt)
   );

   // ALU result closes the loop back to the register file.
   execute u_execute_1 (
      .i_data_a  (data_a),
      .i_data_b  (data_b),
      .i_imm_ext (imm_ext),
      .i_use_imm (use_imm),
      .i_alu_op  (alu_op),
      .o_result  (wb_data)
   );

   assign o_wb_en   = wr_en;
   assign o_wb_reg  = wr_reg;
   assign o_wb_data = wb_data;

endmodule

/* tests/tb_programs.svh */
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// Rows 0 to 2 are fixed programs and row 3 gets random operands at run time.
localparam int NUM_TESTS = 4;
localparam int MAX_LEN   = 16;

// Action applied before a step is checked.
localparam logic [1:0] ACT_NONE  = 2'd0;
localparam logic [1:0] ACT_PAUSE = 2'd1;
localparam logic [1:0] ACT_RESET = 2'd2;

// One executed instruction as seen at the core outputs.
typedef struct packed {
   logic [1:0]  act;
   logic [5:0]  pc;
   logic        wb_en;
   logic [4:0]  wb_reg;
   logic [31:0] wb_data;
} step_t;

string       test_name [NUM_TESTS];
int          word_cnt  [NUM_TESTS];
int          step_cnt  [NUM_TESTS];
logic [31:0] prog      [NUM_TESTS][MAX_LEN];
step_t       steps     [NUM_TESTS][MAX_LEN];

function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [15:0] imm);
   return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                      input logic [4:0] rd, input logic [5:0] fn);
   return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
endfunction

task automatic add_word(input int t, input logic [31:0] word);
   prog[t][word_cnt[t]] = word;
   word_cnt[t]++;
endtask

task automatic add_step(input int t, input logic [1:0] act, input int pc, input logic en,
                        input int wb_reg, input logic [31:0] data);
   steps[t][step_cnt[t]] = {act, pc[5:0], en, wb_reg[4:0], data};
   step_cnt[t]++;
endtask

// Word at the next free address and its expected step.
task automatic add_seq(input int t, input logic [1:0] act, input logic [31:0] word,
                       input logic en, input int wb_reg, input logic [31:0] data);
   add_step(t, act, word_cnt[t], en, wb_reg, data);
   add_word(t, word);
endtask

task automatic build_tables();
   logic [31:0] halt_word;
   halt_word = {OP_HALT, 26'd0};
   // Immediates of both signs, wrapping ALU results, write to r0, and a pause.
   test_name[0] = "arith";
   add_seq(0, ACT_NONE, enc_i(OP_ADDIU, 0, 1, 16'h7fff), 1, 1, 32'h0000_7fff);
   add_seq(0, ACT_NONE, enc_i(OP_ADDIU, 0, 2, 16'hffff), 1, 2, 32'hffff_ffff);
   add_seq(0, ACT_NONE, enc_i(OP_ADDIU, 1, 0, 16'h0003), 1, 0, 32'h0000_8002);
   add_seq(0, ACT_PAUSE, enc_r(2, 1, 3, FN_ADDU), 1, 3, 32'h0000_7ffe);
   add_seq(0, ACT_NONE, enc_r(1, 2, 4, FN_SUBU), 1, 4, 32'h0000_8000);
   add_seq(0, ACT_NONE, enc_r(2, 1, 5, FN_AND), 1, 5, 32'h0000_7fff);
   add_seq(0, ACT_NONE, enc_r(4, 0, 6, FN_OR), 1, 6, 32'h0000_8000);
   add_seq(0, ACT_NONE, enc_r(2, 1, 7, FN_SLT), 1, 7, 32'h0000_0001);
   add_seq(0, ACT_NONE, enc_r(1, 2, 8, FN_SLT), 1, 8, 32'h0000_0000);
   add_seq(0, ACT_NONE, halt_word, 0, 0, 32'h0);
   // Forward jump to 5, fall through at 5, backward jump to 2.
   test_name[1] = "beqz";
   add_seq(1, ACT_NONE, enc_i(OP_ADDIU, 0, 1, 16'h0002), 1, 1, 32'h2);
   add_seq(1, ACT_NONE, enc_i(OP_BEQZ, 0, 0, 16'h0003), 0, 0, 32'h0);
   add_word(1, enc_i(OP_ADDIU, 0, 2, 16'h0007));
   add_word(1, halt_word);
   add_word(1, enc_i(OP_ADDIU, 0, 3, 16'h0001));
   add_seq(1, ACT_NONE, enc_i(OP_BEQZ, 1, 0, 16'h0005), 0, 0, 32'h0);
   add_seq(1, ACT_NONE, enc_i(OP_BEQZ, 0, 0, 16'hfffb), 0, 0, 32'h0);
   add_step(1, ACT_NONE, 2, 1, 2, 32'h7);
   add_step(1, ACT_NONE, 3, 0, 0, 32'h0);
   // Reset after the halt must clear r1 and r2 before the first ADDU.
   test_name[2] = "reset";
   add_seq(2, ACT_NONE, enc_r(1, 2, 3, FN_ADDU), 1, 3, 32'h0);
   add_seq(2, ACT_NONE, enc_i(OP_ADDIU, 0, 1, 16'h0123), 1, 1, 32'h123);
   add_seq(2, ACT_NONE, enc_i(OP_ADDIU, 0, 2, 16'h0456), 1, 2, 32'h456);
   add_seq(2, ACT_NONE, enc_r(1, 2, 4, FN_ADDU), 1, 4, 32'h579);
   add_seq(2, ACT_NONE, halt_word, 0, 0, 32'h0);
   add_step(2, ACT_RESET, 0, 1, 3, 32'h0);
   add_step(2, ACT_NONE, 1, 1, 1, 32'h123);
   add_step(2, ACT_NONE, 2, 1, 2, 32'h456);
   add_step(2, ACT_NONE, 3, 1, 4, 32'h579);
   add_step(2, ACT_NONE, 4, 0, 0, 32'h0);
endtask

`endif

/* tests/tb_mips_core.sv */
`timescale 1ns/10ps

module tb_mips_core
   import mips_pkg::*;
   ();

   logic                  i_clock;
   logic                  i_arst_n;
   logic                  i_run;
   logic                  i_load_en;
   logic [PC_W-1:0]       i_load_addr;
   logic [INSTR_W-1:0]    i_load_data;
   logic [PC_W-1:0]       o_pc;
   logic                  o_halt;
   logic                  o_wb_en;
   logic [REG_ADDR_W-1:0] o_wb_reg;
   logic [DATA_W-1:0]     o_wb_data;

   int    errors;
   int    cycles;
   int    cycle_limit;
   string cur_name;

   `include "tb_programs.svh"

   mips_core mips_core_inst (
      .i_clock     (i_clock),
      .i_arst_n    (i_arst_n),
      .i_run       (i_run),
      .i_load_en   (i_load_en),
      .i_load_addr (i_load_addr),
      .i_load_data (i_load_data),
      .o_pc        (o_pc),
      .o_halt      (o_halt),
      .o_wb_en     (o_wb_en),
      .o_wb_reg    (o_wb_reg),
      .o_wb_data   (o_wb_data)
   );

   // 20 ns clock.
   always #10 i_clock = ~i_clock;

   always @(posedge i_clock) begin
      cycles++;
      if (cycles > cycle_limit) begin
         $display("Timeout after %0d cycles, the core never finished the tests", cycles);
         $display("Test failed");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////
   // Stimulus helpers.
   ////////////////////////////////////////////////////////////////////

   // Inputs change 2 ns after the rising edge.
   task automatic next_cycle();
      @(posedge i_clock);
      #2;
   endtask

   task automatic apply_reset();
      i_arst_n = 1'b0;
      repeat (2) @(posedge i_clock);
      #2;
      i_arst_n = 1'b1;
   endtask

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         $display("CHECK FAILED %s %s: expected %h, actual %h",
                  cur_name, what, expected, actual);
         errors++;
      end
   endtask

   task automatic check_step(input step_t s);
      check_value("o_pc", s.pc, o_pc);
      check_value("o_halt", 1'b0, o_halt);
      check_value("o_wb_en", s.wb_en, o_wb_en);
      if (s.wb_en) begin
         check_value("o_wb_reg", s.wb_reg, o_wb_reg);
         check_value("o_wb_data", s.wb_data, o_wb_data);
      end
   endtask

   // Operands come from sign-extended random immediates.
   task automatic build_random_row(input int t);
      logic [15:0] imm_a;
      logic [15:0] imm_b;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] a_less;
      imm_a = 16'($urandom());
      imm_b = 16'($urandom());
      a = {{16{imm_a[15]}}, imm_a};
      b = {{16{imm_b[15]}}, imm_b};
      // With different signs the negative operand is the smaller one.
      if (a[31] != b[31]) begin
         a_less = a[31] ? 32'd1 : 32'd0;
      end else begin
         a_less = (a < b) ? 32'd1 : 32'd0;
      end
      test_name[t] = "random";
      add_seq(t, ACT_NONE, enc_i(OP_ADDIU, 0, 1, imm_a), 1, 1, a);
      add_seq(t, ACT_NONE, enc_i(OP_ADDIU, 0, 2, imm_b), 1, 2, b);
      add_seq(t, ACT_NONE, enc_r(1, 2, 3, FN_ADDU), 1, 3, a + b);
      add_seq(t, ACT_NONE, enc_r(1, 2, 4, FN_SUBU), 1, 4, a - b);
      add_seq(t, ACT_NONE, enc_r(1, 2, 5, FN_AND), 1, 5, a & b);
      add_seq(t, ACT_NONE, enc_r(1, 2, 6, FN_OR), 1, 6, a | b);
      add_seq(t, ACT_NONE, enc_r(1, 2, 7, FN_SLT), 1, 7, a_less);
      add_seq(t, ACT_NONE, {OP_HALT, 26'd0}, 0, 0, 32'h0);
   endtask

   ////////////////////////////////////////////////////////////////////
   // Reset, load, run and check one table row.
   ////////////////////////////////////////////////////////////////////

   task automatic run_test(input int t);
      step_t s;
      int    i;
      cur_name = test_name[t];
      i_run = 1'b0;
      apply_reset();
      for (i = 0; i < word_cnt[t]; i++) begin
         i_load_en   = 1'b1;
         i_load_addr = PC_W'(i);
         i_load_data = prog[t][i];
         next_cycle();
      end
      i_load_en = 1'b0;
      i_run     = 1'b1;
      for (i = 0; i < step_cnt[t]; i++) begin
         s = steps[t][i];
         if (s.act == ACT_PAUSE) begin
            i_run = 1'b0;
            repeat (4) begin
               #16;
               check_value("o_pc while paused", s.pc, o_pc);
               check_value("o_wb_en while paused", 1'b0, o_wb_en);
               next_cycle();
            end
            i_run = 1'b1;
         end else if (s.act == ACT_RESET) begin
            apply_reset();
         end
         // Sample just before the next rising edge.
         #16;
         check_step(s);
         next_cycle();
      end
      // Last step is a HALT, so the core sits on it from here on.
      repeat (3) begin
         #16;
         check_value("o_halt", 1'b1, o_halt);
         check_value("o_pc after halt", s.pc, o_pc);
         check_value("o_wb_en after halt", 1'b0, o_wb_en);
         next_cycle();
      end
      i_run = 1'b0;
   endtask

   initial begin
      int seed_value;
      int t;
      seed_value  = $urandom(32'h5a31a687);
      errors      = 0;
      cycles      = 0;
      i_clock     = 1'b0;
      i_arst_n    = 1'b0;
      i_run       = 1'b0;
      i_load_en   = 1'b0;
      i_load_addr = '0;
      i_load_data = '0;
      build_tables();
      build_random_row(3);
      cycle_limit = 200;
      for (t = 0; t < NUM_TESTS; t++) begin
         cycle_limit += 40 * step_cnt[t];
      end
      for (t = 0; t < NUM_TESTS; t++) begin
         run_test(t);
      end
      $display("Finished %0d tests with %0d errors", NUM_TESTS, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* all.f */
+incdir+tests
design/mips_pkg.sv
design/instr_fetch.sv
design/decoder.sv
design/register_file.sv
design/instr_decode.sv
design/execute.sv
design/mips_core.sv
tests/tb_mips_core.sv
